/* all.f */
tilesPkg.sv
panelPkg.sv
gameTimer.sv
roundControl.sv
laneEngine.sv
scoreKeeper.sv
toneSynth.sv
pianoTilesTop.sv
pianoTilesTb.sv

/* gameTimer.sv */
`timescale 1ns/1ps

module gameTimer #(
	parameter int tickCycles = 500000, // clocks per frame
	parameter int roundTicks = 3600 // frames per round
) (
	input logic clock,
	input logic reset,
	input logic newRound,
	input tilesPkg::phaseT phase,
	output logic tick,
	output logic roundEnd
);

	localparam int divWidth = $clog2(tickCycles + 1);
	localparam int countWidth = $clog2(roundTicks + 1);

	logic [divWidth-1:0] divCount; // frame divider
	logic [countWidth-1:0] tickCount; // frames played this round

	assign tick = (divCount == divWidth'(tickCycles - 1));

	// the count only moves in play, so this fires once per round
	assign roundEnd = tick && (tickCount == countWidth'(roundTicks - 1));

	always_ff @(posedge clock)
	begin
		if (reset || newRound)
			divCount <= '0; // realign frames to the round start
		else if (tick)
			divCount <= '0;
		else
			divCount <= divCount + divWidth'(1);
	end

	always_ff @(posedge clock)
	begin
		if (reset || newRound)
		begin
			tickCount <= '0;
		end
		else if (tick && (phase == tilesPkg::phasePlay))
		begin
			if (tickCount != countWidth'(roundTicks))
				tickCount <= tickCount + countWidth'(1); // hold at the end
		end
	end

	// round controller must already be in play when the last frame lands
	roundEndInPlay: assert property (@(posedge clock) disable iff (reset)
		roundEnd |-> (phase == tilesPkg::phasePlay))
		else $error("roundEnd outside play");

endmodule

/* laneEngine.sv */
`timescale 1ns/1ps

module laneEngine (
	input logic clock,
	input logic reset,
	input logic tick,
	input logic newRound,
	input tilesPkg::phaseT phase,
	input logic [tilesPkg::numLanes-1:0] keys,
	output tilesPkg::laneArrayT lanes,
	output logic frameStrobe,
	output tilesPkg::frameEventT frameEvent
);

	tilesPkg::laneArrayT nextLanes;
	tilesPkg::frameEventT nextEvent;
	logic [tilesPkg::numLanes-1:0] inZone; // key held with tile in the hit window
	logic frameGo;

	assign frameGo = tick && (phase == tilesPkg::phasePlay); // frames only run in play

	always_comb
	begin
		for (int i = 0; i < tilesPkg::numLanes; i++)
		begin
			inZone[i] = keys[i]
				&& (lanes[i].row >= tilesPkg::hitZoneLow)
				&& (lanes[i].row <= tilesPkg::hitZoneHigh);
		end
	end

	// one frame of the game rule
	always_comb
	begin
		nextEvent = '0;
		nextLanes = lanes;

		// lowest lane wins when several keys land at once
		for (int i = 0; i < tilesPkg::numLanes; i++)
		begin
			if (inZone[i] && !nextEvent.hit)
			begin
				nextEvent.hit = 1'b1;
				nextEvent.note[i] = 1'b1;
			end
		end

		for (int i = 0; i < tilesPkg::numLanes; i++)
		begin
			if (nextEvent.note[i])
			begin
				nextLanes[i].valid = 1'b0; // hit tile stops where it was struck
				nextLanes[i].row = lanes[i].row;
			end
			else
			begin
				nextLanes[i].valid = lanes[i].valid;
				nextLanes[i].row = lanes[i].row + tilesPkg::rowWidth'(1); // wraps at 128
			end

			if ((lanes[i].row == tilesPkg::missRow) && !keys[i])
				nextEvent.miss = 1'b1;

			// tile hit last frame comes back at the bottom
			if (!lanes[i].valid)
				nextLanes[i] = '{valid: 1'b1, row: tilesPkg::respawnRow};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lanes <= '0;
			frameStrobe <= 1'b0;
			frameEvent <= '0;
		end
		else if (newRound)
		begin
			for (int i = 0; i < tilesPkg::numLanes; i++)
			begin
				lanes[i] <= '{valid: 1'b1, row: tilesPkg::startRows[i]};
			end
			frameStrobe <= 1'b0;
		end
		else
		begin
			frameStrobe <= frameGo;
			if (frameGo)
			begin
				lanes <= nextLanes;
				frameEvent <= nextEvent; // held until the next frame
			end
		end
	end

	// score and tone both assume a single lane per note
	oneNote: assert property (@(posedge clock) disable iff (reset)
		frameStrobe |-> $onehot0(frameEvent.note))
		else $error("more than one note bit set");

endmodule

/* panelPkg.sv */
package panelPkg;

	typedef logic [6:0] segT; // active low, segment a in bit 0

	typedef logic signed [31:0] sampleT; // codec sample

	// base half-periods in clocks per lane, scaled up at the top level
	localparam int unsigned toneHalfPeriods [5] = '{191, 170, 152, 143, 128};

	// standard hex glyphs for one digit
	function automatic segT hexToSeg(input logic [3:0] nibble);
		segT seg;
		case (nibble)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'ha: seg = 7'b0001000;
			4'hb: seg = 7'b0000011;
			4'hc: seg = 7'b1000110;
			4'hd: seg = 7'b0100001;
			4'he: seg = 7'b0000110;
			default: seg = 7'b0001110; // F
		endcase
		return seg;
	endfunction

endpackage

/* pianoTilesTb.sv */
`timescale 1ns/1ps

module pianoTilesTb;

	localparam int tickCycles = 8;
	localparam int roundTicks = 40;
	localparam int amplitude = 12345;
	localparam int frameTimeout = 4 * tickCycles; // cycles allowed per frame wait

	// game rule as the model sees it
	localparam int hitLow = 105;
	localparam int hitHigh = 119;
	localparam int missRow = 120;
	localparam int respawnRow = 120;
	localparam int startRow [5] = '{1, 16, 66, 88, 127};

	// lit segments gfedcba for 0 to F, the panel shows them inverted
	localparam logic [6:0] litSegs [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
		7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic clock = 1'b0;
	logic reset;
	logic [4:0] keys;
	logic restart;
	logic [39:0] lanes;
	logic frameStrobe;
	logic over;
	logic [13:0] scoreDigits;
	logic [13:0] highDigits;
	logic signed [31:0] sample;

	int modelRow [5];
	bit modelValid [5];
	int modelScore;
	int modelHigh;
	int errorCount;
	int testErrors; // errors in the running test
	int testsRun;
	int currentTest;
	bit aborted;

	pianoTilesTop #(
		.tickCycles(tickCycles),
		.roundTicks(roundTicks),
		.toneScale(1),
		.amplitude(amplitude)
	) pianoTilesTop_inst (
		.clock(clock),
		.reset(reset),
		.keys(keys),
		.restart(restart),
		.lanes(lanes),
		.frameStrobe(frameStrobe),
		.over(over),
		.scoreDigits(scoreDigits),
		.highDigits(highDigits),
		.sample(sample)
	);

	always #5 clock = ~clock; // 10 ns

	// high digit in the upper slot
	function automatic logic [13:0] digitPair(input int value);
		return {~litSegs[(value >> 4) & 15], ~litSegs[value & 15]};
	endfunction

	function automatic logic [39:0] packLanes();
		logic [39:0] packedLanes;
		for (int i = 0; i < 5; i++)
			packedLanes[i*8 +: 8] = {modelValid[i], 7'(modelRow[i])}; // lane 0 lowest
		return packedLanes;
	endfunction

	function automatic int magnitude(input logic signed [31:0] value);
		return (value < 0) ? -int'(value) : int'(value);
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want)
		begin
			$display("FAIL %s got 0x%0h want 0x%0h", name, got, want);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic loadModel();
		for (int i = 0; i < 5; i++)
		begin
			modelRow[i] = startRow[i];
			modelValid[i] = 1'b1;
		end
	endtask

	// one frame of the game rule, gives back the one-hot note
	task automatic stepModel(input logic [4:0] k, output logic [4:0] note);
		int hitLane;
		bit miss;
		bit wasInvalid;
		hitLane = -1;
		miss = 1'b0;
		for (int i = 0; i < 5; i++)
		begin
			if (hitLane < 0 && k[i] && modelRow[i] >= hitLow && modelRow[i] <= hitHigh)
				hitLane = i; // lowest lane first
			if (modelRow[i] == missRow && !k[i])
				miss = 1'b1;
		end
		for (int i = 0; i < 5; i++)
		begin
			wasInvalid = !modelValid[i];
			if (i == hitLane)
				modelValid[i] = 1'b0; // row stays put
			else
				modelRow[i] = (modelRow[i] + 1) % 128;
			if (wasInvalid)
			begin
				modelValid[i] = 1'b1;
				modelRow[i] = respawnRow;
			end
		end
		if (miss)
		begin
			if (modelScore > 0)
				modelScore--;
		end
		else if (hitLane >= 0)
		begin
			modelScore++;
		end
		note = (hitLane >= 0) ? 5'(1 << hitLane) : 5'd0;
	endtask

	// sample between edges so the DUT has settled
	task automatic waitFrame(output bit seen);
		seen = 1'b0;
		for (int n = 0; n < frameTimeout && !seen; n++)
		begin
			@(negedge clock);
			seen = frameStrobe;
		end
		if (!seen)
		begin
			$display("ERROR: no frame strobe within %0d cycles", frameTimeout);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic playFrames(input int frames, input logic [4:0] mask);
		logic [4:0] note;
		bit seen;
		@(posedge clock);
		keys <= mask; // held for every frame of the step
		for (int f = 0; f < frames && !aborted; f++)
		begin
			waitFrame(seen);
			if (!seen)
			begin
				aborted = 1'b1;
			end
			else
			begin
				stepModel(mask, note);
				checkValue("lanes", 64'(lanes), 64'(packLanes()));
				@(negedge clock); // score and tone follow a cycle later
				checkValue("sample", 64'(magnitude(sample)), 64'((note != 0) ? amplitude : 0));
			end
		end
	endtask

	task automatic restartRound();
		bit seen;
		bit cleared;
		seen = 1'b0;
		cleared = 1'b0;
		for (int n = 0; n < 3 * tickCycles; n++)
		begin
			@(negedge clock);
			if (frameStrobe)
				seen = 1'b1;
		end
		if (seen)
		begin
			$display("ERROR: frame strobe while the round is over");
			errorCount++;
			testErrors++;
		end
		@(posedge clock);
		keys <= '0;
		restart <= 1'b1;
		@(posedge clock);
		restart <= 1'b0;
		for (int n = 0; n < frameTimeout && !cleared; n++)
		begin
			@(negedge clock);
			cleared = !over;
		end
		if (!cleared)
		begin
			$display("ERROR: over flag did not drop after restart");
			errorCount++;
			testErrors++;
			aborted = 1'b1;
		end
		else
		begin
			@(negedge clock); // new round clears one cycle after the phase change
			if (modelScore > modelHigh)
				modelHigh = modelScore;
			modelScore = 0;
			loadModel();
			checkValue("lanes", 64'(lanes), 64'(packLanes()));
		end
	endtask

	task automatic checkPanel(input int score, input int high, input int overWant);
		if (score != modelScore || high != modelHigh)
		begin
			$display("ERROR: data file wants score %0d high %0d but the model has %0d and %0d",
				score, high, modelScore, modelHigh);
			errorCount++;
			testErrors++;
		end
		checkValue("scoreDigits", 64'(scoreDigits), 64'(digitPair(score)));
		checkValue("highDigits", 64'(highDigits), 64'(digitPair(high)));
		checkValue("over", 64'(over), 64'(overWant));
	endtask

	task automatic reportTest();
		if (testErrors == 0)
			$display("test %0d: pass", currentTest);
		else
			$display("test %0d: %0d errors", currentTest, testErrors);
		testsRun++;
		testErrors = 0;
	endtask

	initial
	begin
		int fd;
		int code;
		int test;
		int frames;
		int mask;
		int score;
		int high;
		int overWant;
		string line;
		reset = 1'b1;
		keys = '0;
		restart = 1'b0;
		errorCount = 0;
		testErrors = 0;
		testsRun = 0;
		currentTest = 0;
		aborted = 1'b0;
		modelScore = 0;
		modelHigh = 0;
		loadModel();
		fd = $fopen("testdata.txt", "r");
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		// test 0 is the state right after reset
		@(negedge clock);
		checkValue("lanes", 64'(lanes), 64'd0);
		checkValue("sample", 64'(sample), 64'd0);
		checkPanel(0, 0, 0);
		@(negedge clock); // start phase loads the rows
		checkValue("lanes", 64'(lanes), 64'(packLanes()));

		if (fd == 0)
		begin
			$display("ERROR: cannot open testdata.txt");
			errorCount++;
			aborted = 1'b1;
		end
		while (!aborted && $fgets(line, fd) > 0)
		begin
			code = $sscanf(line, "%d %d %h %d %d %d", test, frames, mask, score, high, overWant);
			if (code == 6) // comment lines fall through
			begin
				if (test != currentTest)
				begin
					reportTest();
					currentTest = test;
				end
				if (frames == 0)
					restartRound();
				else
					playFrames(frames, 5'(mask));
				if (!aborted)
					checkPanel(score, high, overWant);
			end
		end
		if (fd != 0)
			$fclose(fd);
		reportTest();
		$display("%0d tests run, %0d errors", testsRun, errorCount);
		if (errorCount == 0 && !aborted)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* pianoTilesTop.sv */
`timescale 1ns/1ps

module pianoTilesTop #(
	parameter int tickCycles = 500000, // clocks per frame
	parameter int roundTicks = 3600, // frames per round
	parameter int toneScale = 500,
	parameter int amplitude = 10000000
) (
	input logic clock,
	input logic reset,
	input logic [tilesPkg::numLanes-1:0] keys,
	input logic restart,
	output tilesPkg::laneArrayT lanes, // for an outside renderer
	output logic frameStrobe,
	output logic over,
	output panelPkg::segT [1:0] scoreDigits,
	output panelPkg::segT [1:0] highDigits,
	output panelPkg::sampleT sample // for an outside codec
);

	logic tick;
	logic roundEnd;
	logic newRound;
	tilesPkg::phaseT phase;
	tilesPkg::frameEventT frameEvent;

	gameTimer #(
		.tickCycles(tickCycles),
		.roundTicks(roundTicks)
	) gameTimerInst (
		.clock(clock),
		.reset(reset),
		.newRound(newRound),
		.phase(phase),
		.tick(tick),
		.roundEnd(roundEnd)
	);

	roundControl roundControlInst (
		.clock(clock),
		.reset(reset),
		.roundEnd(roundEnd),
		.restart(restart),
		.phase(phase),
		.newRound(newRound),
		.over(over)
	);

	laneEngine laneEngineInst (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.newRound(newRound),
		.phase(phase),
		.keys(keys),
		.lanes(lanes),
		.frameStrobe(frameStrobe),
		.frameEvent(frameEvent)
	);

	scoreKeeper scoreKeeperInst (
		.clock(clock),
		.reset(reset),
		.newRound(newRound),
		.frameStrobe(frameStrobe),
		.frameEvent(frameEvent),
		.scoreDigits(scoreDigits),
		.highDigits(highDigits)
	);

	toneSynth #(
		.toneScale(toneScale),
		.amplitude(amplitude)
	) toneSynthInst (
		.clock(clock),
		.reset(reset),
		.frameStrobe(frameStrobe),
		.frameEvent(frameEvent),
		.sample(sample)
	);

endmodule

/* roundControl.sv */
`timescale 1ns/1ps

module roundControl (
	input logic clock,
	input logic reset,
	input logic roundEnd,
	input logic restart,
	output tilesPkg::phaseT phase,
	output logic newRound,
	output logic over
);

	tilesPkg::phaseT phaseNext;

	// next phase
	always_comb
	begin
		phaseNext = phase;
		case (phase)
			tilesPkg::phaseStart:
			begin
				phaseNext = tilesPkg::phasePlay; // setup takes one cycle
			end
			tilesPkg::phasePlay:
			begin
				if (roundEnd)
					phaseNext = tilesPkg::phaseOver;
			end
			tilesPkg::phaseOver:
			begin
				if (restart)
					phaseNext = tilesPkg::phaseStart; // player asked for another round
			end
			default:
			begin
				phaseNext = tilesPkg::phaseStart;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			phase <= tilesPkg::phaseStart;
		else
			phase <= phaseNext;
	end

	// start lasts a single cycle so this is a pulse
	assign newRound = (phase == tilesPkg::phaseStart);
	assign over = (phase == tilesPkg::phaseOver); // game over flag for the panel

	// timer, lanes and score all expect a single clear per round
	newRoundPulse: assert property (@(posedge clock) disable iff (reset)
		newRound |=> !newRound)
		else $error("newRound longer than one cycle");

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds and runs the testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module pianoTilesTb -f all.f -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "All tests passed!"; then
	exit 0
else
	exit 1
fi

/* scoreKeeper.sv */
`timescale 1ns/1ps

module scoreKeeper (
	input logic clock,
	input logic reset,
	input logic newRound,
	input logic frameStrobe,
	input tilesPkg::frameEventT frameEvent,
	output panelPkg::segT [1:0] scoreDigits,
	output panelPkg::segT [1:0] highDigits
);

	logic [7:0] score;
	logic [7:0] highScore; // best score of earlier rounds

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			score <= '0;
			highScore <= '0;
		end
		else if (newRound)
		begin
			if (score > highScore)
				highScore <= score; // keep the better of the two
			score <= '0;
		end
		else if (frameStrobe)
		begin
			// a miss beats a hit in the same frame
			if (frameEvent.miss)
			begin
				if (score != 8'd0)
					score <= score - 8'd1; // floor at zero
			end
			else if (frameEvent.hit)
			begin
				score <= score + 8'd1;
			end
		end
	end

	// digit 0 is the low nibble
	assign scoreDigits[0] = panelPkg::hexToSeg(score[3:0]);
	assign scoreDigits[1] = panelPkg::hexToSeg(score[7:4]);
	assign highDigits[0] = panelPkg::hexToSeg(highScore[3:0]);
	assign highDigits[1] = panelPkg::hexToSeg(highScore[7:4]);

	// misses at zero must not roll the score over
	noUnderflow: assert property (@(posedge clock) disable iff (reset)
		(score == 8'd0) |=> (score != 8'hff))
		else $error("score wrapped below zero");

endmodule

/* testdata.txt */
# test frames keys(hex) score high over, frames 0 pulses restart
# keys are held for every frame of the line, score and high are decimal
1 1 00 0 0 0
2 16 00 0 0 0
3 1 08 1 0 0
4 1 00 1 0 0
5 1 00 0 0 0
6 19 00 0 0 0
7 1 04 1 0 1
8 0 00 0 1 0
9 32 00 0 1 0
10 1 00 0 1 0
11 6 00 0 1 0
12 1 1f 1 1 1
13 0 00 0 1 0
14 17 00 0 1 0
15 1 18 1 1 0
16 1 00 1 1 0
17 1 08 1 1 0
18 19 00 1 1 0
19 1 04 2 1 1
20 0 00 0 2 0
21 1 00 0 2 0

/* tilesPkg.sv */
package tilesPkg;

	// playfield geometry
	localparam int numLanes = 5;
	localparam int rowWidth = 7; // rows 0 to 127

	// hit window, both ends inclusive
	localparam logic [rowWidth-1:0] hitZoneLow = 7'd105;
	localparam logic [rowWidth-1:0] hitZoneHigh = 7'd119;

	localparam logic [rowWidth-1:0] missRow = 7'd120; // unhit tile here counts as a miss
	localparam logic [rowWidth-1:0] respawnRow = 7'd120; // hit tiles come back here

	// staggered rows at the top of a round, lane 0 in the low slot
	localparam logic [numLanes-1:0][rowWidth-1:0] startRows = {
		7'd127,
		7'd88,
		7'd66,
		7'd16,
		7'd1
	};

	// one falling tile
	typedef struct packed {
		logic valid;
		logic [rowWidth-1:0] row;
	} laneT;

	typedef laneT [numLanes-1:0] laneArrayT; // whole playfield, 40 bits

	// result of one frame update
	typedef struct packed {
		logic hit;
		logic miss;
		logic [numLanes-1:0] note; // one-hot lane that was hit
	} frameEventT;

	typedef enum logic [1:0] {
		phaseStart,
		phasePlay,
		phaseOver
	} phaseT;

endpackage

/* toneSynth.sv */
`timescale 1ns/1ps

module toneSynth #(
	parameter int toneScale = 500, // stretches the base half-periods
	parameter int amplitude = 10000000
) (
	input logic clock,
	input logic reset,
	input logic frameStrobe,
	input tilesPkg::frameEventT frameEvent,
	output panelPkg::sampleT sample
);

	logic [tilesPkg::numLanes-1:0] noteReg; // lane that was last hit
	logic [2:0] laneIndex;
	logic [31:0] halfPeriod;
	logic [31:0] waveCount;
	logic level; // square wave polarity

	always_comb
	begin
		laneIndex = '0;
		for (int i = 0; i < tilesPkg::numLanes; i++)
		begin
			if (noteReg[i])
				laneIndex = 3'(i);
		end
	end

	assign halfPeriod = 32'(panelPkg::toneHalfPeriods[laneIndex] * toneScale);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			noteReg <= '0;
			waveCount <= '0;
			level <= 1'b0;
		end
		else if (frameStrobe && (frameEvent.note != noteReg))
		begin
			noteReg <= frameEvent.note; // new pitch starts a fresh cycle
			waveCount <= '0;
			level <= 1'b0;
		end
		else if (waveCount >= halfPeriod - 32'd1)
		begin
			waveCount <= '0;
			level <= !level;
		end
		else
		begin
			waveCount <= waveCount + 32'd1;
		end
	end

	// silent when nothing was hit
	assign sample = (noteReg == '0) ? '0
		: level ? panelPkg::sampleT'(amplitude) : -panelPkg::sampleT'(amplitude);

endmodule
